// ==== rtl/llc_defs.svh ====
//////////////////////////////////////////////////////////////////////
// LLC geometry macros
//////////////////////////////////////////////////////////////////////

`ifndef LLC_DEFS_SVH
`define LLC_DEFS_SVH

// set organisation
`define LLC_SETS 16
`define LLC_WAYS 4
`define LLC_SET_BITS 4
`define LLC_WAY_BITS 2

// address and line widths
`define LLC_ADDR_BITS 16
`define LLC_TAG_BITS (`LLC_ADDR_BITS - `LLC_SET_BITS)
`define LLC_LINE_BITS 32

`endif

// ==== rtl/llc_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// LLC vector types
//////////////////////////////////////////////////////////////////////

`include "llc_defs.svh"

package llc_types_pkg;

    // full line address, tag above set
    typedef logic [`LLC_ADDR_BITS-1:0] line_addr_t;

    // address fields
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    // way index into a set
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    // one line is one data word
    typedef logic [`LLC_LINE_BITS-1:0] line_t;

endpackage

// ==== rtl/llc_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// LLC command and line state encodings
//////////////////////////////////////////////////////////////////////

package llc_ctrl_pkg;

    // request command
    typedef enum logic {
        LLC_CMD_READ  = 1'b0,
        LLC_CMD_WRITE = 1'b1
    } llc_cmd_t;

    // line state, dirty lines need a write-back on eviction
    typedef enum logic [1:0] {
        LLC_INVALID = 2'd0,
        LLC_CLEAN   = 2'd1,
        LLC_DIRTY   = 2'd2
    } llc_state_t;

endpackage

// ==== rtl/llc_input_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// LLC input side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "llc_defs.svh"

module llc_input_decoder
    import llc_types_pkg::*, llc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid_i,
    input  llc_cmd_t   req_cmd_i,
    input  line_addr_t req_addr_i,
    input  line_t      req_wdata_i,
    output logic       req_ready_o,
    input  logic       mem_rsp_valid_i,
    input  line_t      mem_rsp_data_i,
    output logic       mem_rsp_ready_o,
    input  logic       req_done_i,
    input  logic       fill_wait_i,
    input  logic       fill_taken_i,
    output logic       req_pend_o,
    output llc_cmd_t   req_cmd_o,
    output llc_set_t   req_set_o,
    output llc_tag_t   req_tag_o,
    output line_t      req_data_o,
    output logic       fill_pend_o,
    output line_t      fill_data_o
);

    logic req_fire;
    logic fill_fire;

    // one request in flight at a time
    assign req_ready_o     = !req_pend_o;
    assign req_fire        = req_valid_i && req_ready_o;
    assign mem_rsp_ready_o = fill_wait_i && !fill_pend_o;
    assign fill_fire       = mem_rsp_valid_i && mem_rsp_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_pend_o  <= 1'b0;
            fill_pend_o <= 1'b0;
        end else begin
            if (req_fire) begin
                req_pend_o <= 1'b1;
            end else if (req_done_i) begin
                req_pend_o <= 1'b0;
            end
            if (fill_fire) begin
                fill_pend_o <= 1'b1;
            end else if (fill_taken_i) begin
                fill_pend_o <= 1'b0;
            end
        end
    end

    // request and fill payloads
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_cmd_o  <= req_cmd_i;
            req_set_o  <= req_addr_i[`LLC_SET_BITS-1:0];
            req_tag_o  <= req_addr_i[`LLC_ADDR_BITS-1:`LLC_SET_BITS];
            req_data_o <= req_wdata_i;
        end
        if (fill_fire) begin
            fill_data_o <= mem_rsp_data_i;
        end
    end

    // memory only answers a fetch the FSM is waiting for
    a_no_stray_fill: assert property (@(posedge clk) disable iff (!rst)
        mem_rsp_valid_i |-> fill_wait_i);

endmodule

// ==== rtl/llc_localmem.sv ====
//////////////////////////////////////////////////////////////////////
// LLC tag, state, data and eviction arrays
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "llc_defs.svh"

module llc_localmem
    import llc_types_pkg::*, llc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_en_i,
    input  llc_set_t   rd_set_i,
    input  logic       wr_en_i,
    input  llc_set_t   wr_set_i,
    input  llc_way_t   wr_way_i,
    input  llc_tag_t   wr_tag_i,
    input  llc_state_t wr_state_i,
    input  line_t      wr_line_i,
    input  logic       evict_advance_i,
    output llc_tag_t   rd_tags_o [`LLC_WAYS],
    output llc_state_t rd_states_o [`LLC_WAYS],
    output line_t      rd_lines_o [`LLC_WAYS],
    output llc_way_t   rd_evict_way_o
);

    llc_tag_t   tags_q   [`LLC_SETS][`LLC_WAYS];
    llc_state_t states_q [`LLC_SETS][`LLC_WAYS];
    line_t      lines_q  [`LLC_SETS][`LLC_WAYS];
    llc_way_t   evict_q  [`LLC_SETS];

    // states and pointers start invalid and zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_q[s] <= '0;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    states_q[s][w] <= LLC_INVALID;
                end
            end
        end else begin
            if (wr_en_i) begin
                states_q[wr_set_i][wr_way_i] <= wr_state_i;
            end
            // round robin over full sets
            if (evict_advance_i) begin
                evict_q[wr_set_i] <= evict_q[wr_set_i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags_q[wr_set_i][wr_way_i]  <= wr_tag_i;
            lines_q[wr_set_i][wr_way_i] <= wr_line_i;
        end
    end

    // whole set read, one cycle
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                rd_tags_o[w]   <= tags_q[rd_set_i][w];
                rd_states_o[w] <= states_q[rd_set_i][w];
                rd_lines_o[w]  <= lines_q[rd_set_i][w];
            end
            rd_evict_way_o <= evict_q[rd_set_i];
        end
    end

    a_no_rw_collision: assert property (@(posedge clk) disable iff (!rst)
        !(rd_en_i && wr_en_i && (rd_set_i == wr_set_i)));

endmodule

// ==== rtl/llc_lookup_way.sv ====
//////////////////////////////////////////////////////////////////////
// LLC way lookup and victim choice
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "llc_defs.svh"

module llc_lookup_way
    import llc_types_pkg::*, llc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lookup_en_i,
    input  llc_tag_t   tag_i,
    input  llc_tag_t   tags_i [`LLC_WAYS],
    input  llc_state_t states_i [`LLC_WAYS],
    input  line_t      lines_i [`LLC_WAYS],
    input  llc_way_t   evict_way_i,
    output logic       hit_o,
    output llc_way_t   hit_way_o,
    output line_t      hit_line_o,
    output llc_way_t   victim_way_o,
    output llc_tag_t   victim_tag_o,
    output llc_state_t victim_state_o,
    output line_t      victim_line_o
);

    logic [`LLC_WAYS-1:0] hit_vec;
    llc_way_t             hit_way;
    llc_way_t             inv_way;
    logic                 inv_found;
    llc_way_t             victim_way;

    // walk down so the lowest matching way wins
    always_comb begin
        hit_way   = '0;
        inv_way   = '0;
        inv_found = 1'b0;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            hit_vec[w] = (states_i[w] != LLC_INVALID) && (tags_i[w] == tag_i);
            if (hit_vec[w]) begin
                hit_way = llc_way_t'(w);
            end
            if (states_i[w] == LLC_INVALID) begin
                inv_way   = llc_way_t'(w);
                inv_found = 1'b1;
            end
        end
    end

    // free way first, else the set's pointer
    assign victim_way = inv_found ? inv_way : evict_way_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o <= 1'b0;
        end else if (lookup_en_i) begin
            hit_o <= |hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en_i) begin
            hit_way_o      <= hit_way;
            hit_line_o     <= lines_i[hit_way];
            victim_way_o   <= victim_way;
            victim_tag_o   <= tags_i[victim_way];
            victim_state_o <= states_i[victim_way];
            victim_line_o  <= lines_i[victim_way];
        end
    end

    a_single_hit: assert property (@(posedge clk) disable iff (!rst)
        lookup_en_i |-> $onehot0(hit_vec));

endmodule

// ==== rtl/llc_process_request.sv ====
//////////////////////////////////////////////////////////////////////
// LLC request processing FSM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_process_request
    import llc_types_pkg::*, llc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_pend_i,
    input  llc_cmd_t   req_cmd_i,
    input  llc_set_t   req_set_i,
    input  llc_tag_t   req_tag_i,
    input  line_t      req_data_i,
    input  logic       fill_pend_i,
    input  line_t      fill_data_i,
    input  logic       hit_i,
    input  llc_way_t   hit_way_i,
    input  line_t      hit_line_i,
    input  llc_way_t   victim_way_i,
    input  llc_tag_t   victim_tag_i,
    input  llc_state_t victim_state_i,
    input  line_t      victim_line_i,
    input  logic       rsp_busy_i,
    input  logic       mem_busy_i,
    output logic       rd_en_o,
    output llc_set_t   rd_set_o,
    output logic       wr_en_o,
    output llc_set_t   wr_set_o,
    output llc_way_t   wr_way_o,
    output llc_tag_t   wr_tag_o,
    output llc_state_t wr_state_o,
    output line_t      wr_line_o,
    output logic       evict_advance_o,
    output logic       lookup_en_o,
    output logic       rsp_load_o,
    output line_t      rsp_data_o,
    output logic       mem_load_o,
    output logic       mem_write_o,
    output line_addr_t mem_addr_o,
    output line_t      mem_data_o,
    output logic       fill_wait_o,
    output logic       fill_taken_o,
    output logic       req_done_o
);

    typedef enum logic [2:0] {
        S_SET, S_ARRAY, S_PROCESS, S_WB, S_FETCH, S_FILL, S_UPDATE, S_DONE
    } proc_state_t;

    proc_state_t state_q;
    proc_state_t state_nxt;
    logic        is_write;

    assign is_write = (req_cmd_i == LLC_CMD_WRITE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= S_SET;
        end else begin
            state_q <= state_nxt;
        end
    end

    // array and response payloads, qualified by the strobes below
    assign rd_set_o   = req_set_i;
    assign wr_set_o   = req_set_i;
    assign wr_way_o   = hit_i ? hit_way_i : victim_way_i;
    assign wr_tag_o   = req_tag_i;
    assign wr_state_o = is_write ? LLC_DIRTY : LLC_CLEAN;
    assign wr_line_o  = is_write ? req_data_i : fill_data_i;
    assign rsp_data_o = is_write ? req_data_i : (hit_i ? hit_line_i : fill_data_i);
    assign mem_data_o = victim_line_i;

    always_comb begin
        state_nxt       = state_q;
        rd_en_o         = 1'b0;
        lookup_en_o     = 1'b0;
        wr_en_o         = 1'b0;
        evict_advance_o = 1'b0;
        rsp_load_o      = 1'b0;
        mem_load_o      = 1'b0;
        mem_write_o     = 1'b0;
        mem_addr_o      = {req_tag_i, req_set_i};
        fill_wait_o     = 1'b0;
        fill_taken_o    = 1'b0;
        req_done_o      = 1'b0;
        case (state_q)
            S_SET: begin
                if (req_pend_i) begin
                    rd_en_o   = 1'b1;
                    state_nxt = S_ARRAY;
                end
            end
            S_ARRAY: begin
                lookup_en_o = 1'b1;
                state_nxt   = S_PROCESS;
            end
            S_PROCESS: begin
                if (hit_i) begin
                    state_nxt = S_UPDATE;
                end else if (victim_state_i == LLC_DIRTY) begin
                    state_nxt = S_WB;
                end else begin
                    state_nxt = is_write ? S_UPDATE : S_FETCH;
                end
            end
            S_WB: begin
                if (!mem_busy_i) begin
                    mem_load_o  = 1'b1;
                    mem_write_o = 1'b1;
                    mem_addr_o  = {victim_tag_i, req_set_i};
                    state_nxt   = is_write ? S_UPDATE : S_FETCH;
                end
            end
            S_FETCH: begin
                if (!mem_busy_i) begin
                    mem_load_o = 1'b1;
                    state_nxt  = S_FILL;
                end
            end
            S_FILL: begin
                fill_wait_o = 1'b1;
                if (fill_pend_i) begin
                    state_nxt = S_UPDATE;
                end
            end
            S_UPDATE: begin
                if (!rsp_busy_i) begin
                    // read hits leave the arrays untouched
                    wr_en_o         = is_write || !hit_i;
                    evict_advance_o = !hit_i && (victim_state_i != LLC_INVALID);
                    fill_taken_o    = !is_write && !hit_i;
                    rsp_load_o      = 1'b1;
                    state_nxt       = S_DONE;
                end
            end
            S_DONE: begin
                // hold off the next request until the response drains
                if (!rsp_busy_i) begin
                    req_done_o = 1'b1;
                    state_nxt  = S_SET;
                end
            end
            default: begin
                state_nxt = S_SET;
            end
        endcase
    end

    a_mem_slot_free: assert property (@(posedge clk) disable iff (!rst)
        mem_load_o |-> !mem_busy_i ##1 mem_busy_i);

endmodule

// ==== rtl/llc_output_regs.sv ====
//////////////////////////////////////////////////////////////////////
// LLC output side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_output_regs
    import llc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rsp_load_i,
    input  line_t      rsp_data_i,
    input  logic       rsp_ready_i,
    output logic       rsp_valid_o,
    output line_t      rsp_data_o,
    input  logic       mem_load_i,
    input  logic       mem_write_i,
    input  line_addr_t mem_addr_i,
    input  line_t      mem_data_i,
    input  logic       mem_req_ready_i,
    output logic       mem_req_valid_o,
    output logic       mem_req_write_o,
    output line_addr_t mem_req_addr_o,
    output line_t      mem_req_data_o,
    output logic       rsp_busy_o,
    output logic       mem_busy_o
);

    assign rsp_busy_o = rsp_valid_o;
    assign mem_busy_o = mem_req_valid_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
        end else begin
            if (rsp_load_i) begin
                rsp_valid_o <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end
            if (mem_load_i) begin
                mem_req_valid_o <= 1'b1;
            end else if (mem_req_ready_i) begin
                mem_req_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load_i) begin
            rsp_data_o <= rsp_data_i;
        end
        if (mem_load_i) begin
            mem_req_write_o <= mem_write_i;
            mem_req_addr_o  <= mem_addr_i;
            mem_req_data_o  <= mem_data_i;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o));

    a_mem_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
            && $stable({mem_req_write_o, mem_req_addr_o, mem_req_data_o}));

endmodule

// ==== rtl/llc_core.sv ====
//////////////////////////////////////////////////////////////////////
// LLC slice top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "llc_defs.svh"

module llc_core
    import llc_types_pkg::*, llc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid_i,
    input  llc_cmd_t   req_cmd_i,
    input  line_addr_t req_addr_i,
    input  line_t      req_wdata_i,
    output logic       req_ready_o,
    output logic       rsp_valid_o,
    output line_t      rsp_data_o,
    input  logic       rsp_ready_i,
    output logic       mem_req_valid_o,
    output logic       mem_req_write_o,
    output line_addr_t mem_req_addr_o,
    output line_t      mem_req_data_o,
    input  logic       mem_req_ready_i,
    input  logic       mem_rsp_valid_i,
    input  line_t      mem_rsp_data_i,
    output logic       mem_rsp_ready_o
);

    // decoder and FSM handshakes
    logic       req_pend, req_done, fill_pend, fill_wait, fill_taken;
    llc_cmd_t   req_cmd;
    llc_set_t   req_set;
    llc_tag_t   req_tag;
    line_t      req_data, fill_data;

    // array ports
    logic       rd_en, wr_en, evict_advance;
    llc_set_t   rd_set, wr_set;
    llc_way_t   wr_way, rd_evict_way;
    llc_tag_t   wr_tag;
    llc_state_t wr_state;
    line_t      wr_line;
    llc_tag_t   rd_tags [`LLC_WAYS];
    llc_state_t rd_states [`LLC_WAYS];
    line_t      rd_lines [`LLC_WAYS];

    // lookup results
    logic       lookup_en, hit;
    llc_way_t   hit_way, victim_way;
    line_t      hit_line, victim_line;
    llc_tag_t   victim_tag;
    llc_state_t victim_state;

    // output side
    logic       rsp_load, mem_load, mem_write, rsp_busy, mem_busy;
    line_t      rsp_data, mem_data;
    line_addr_t mem_addr;

    llc_input_decoder input_decoder_u (
        .clk, .rst, .req_valid_i, .req_cmd_i, .req_addr_i, .req_wdata_i, .req_ready_o,
        .mem_rsp_valid_i, .mem_rsp_data_i, .mem_rsp_ready_o,
        .req_done_i(req_done), .fill_wait_i(fill_wait), .fill_taken_i(fill_taken),
        .req_pend_o(req_pend), .req_cmd_o(req_cmd), .req_set_o(req_set),
        .req_tag_o(req_tag), .req_data_o(req_data),
        .fill_pend_o(fill_pend), .fill_data_o(fill_data)
    );

    llc_localmem localmem_u (
        .clk, .rst, .rd_en_i(rd_en), .rd_set_i(rd_set),
        .wr_en_i(wr_en), .wr_set_i(wr_set), .wr_way_i(wr_way), .wr_tag_i(wr_tag),
        .wr_state_i(wr_state), .wr_line_i(wr_line), .evict_advance_i(evict_advance),
        .rd_tags_o(rd_tags), .rd_states_o(rd_states), .rd_lines_o(rd_lines),
        .rd_evict_way_o(rd_evict_way)
    );

    llc_lookup_way lookup_way_u (
        .clk, .rst, .lookup_en_i(lookup_en), .tag_i(req_tag),
        .tags_i(rd_tags), .states_i(rd_states), .lines_i(rd_lines),
        .evict_way_i(rd_evict_way),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line),
        .victim_way_o(victim_way), .victim_tag_o(victim_tag),
        .victim_state_o(victim_state), .victim_line_o(victim_line)
    );

    llc_process_request process_request_u (
        .clk, .rst, .req_pend_i(req_pend), .req_cmd_i(req_cmd), .req_set_i(req_set),
        .req_tag_i(req_tag), .req_data_i(req_data),
        .fill_pend_i(fill_pend), .fill_data_i(fill_data),
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_way_i(victim_way), .victim_tag_i(victim_tag),
        .victim_state_i(victim_state), .victim_line_i(victim_line),
        .rsp_busy_i(rsp_busy), .mem_busy_i(mem_busy),
        .rd_en_o(rd_en), .rd_set_o(rd_set), .wr_en_o(wr_en), .wr_set_o(wr_set),
        .wr_way_o(wr_way), .wr_tag_o(wr_tag), .wr_state_o(wr_state), .wr_line_o(wr_line),
        .evict_advance_o(evict_advance), .lookup_en_o(lookup_en),
        .rsp_load_o(rsp_load), .rsp_data_o(rsp_data),
        .mem_load_o(mem_load), .mem_write_o(mem_write), .mem_addr_o(mem_addr),
        .mem_data_o(mem_data), .fill_wait_o(fill_wait), .fill_taken_o(fill_taken),
        .req_done_o(req_done)
    );

    llc_output_regs output_regs_u (
        .clk, .rst, .rsp_load_i(rsp_load), .rsp_data_i(rsp_data), .rsp_ready_i,
        .rsp_valid_o, .rsp_data_o,
        .mem_load_i(mem_load), .mem_write_i(mem_write), .mem_addr_i(mem_addr),
        .mem_data_i(mem_data), .mem_req_ready_i,
        .mem_req_valid_o, .mem_req_write_o, .mem_req_addr_o, .mem_req_data_o,
        .rsp_busy_o(rsp_busy), .mem_busy_o(mem_busy)
    );

endmodule

// ==== verif/llc_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// LLC slice testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "llc_defs.svh"

module llc_core_tb
    import llc_types_pkg::*, llc_ctrl_pkg::*;
();

    localparam int N_ROWS     = 21;
    localparam int ROW_CYCLES = 120;
    localparam int MEM_WORDS  = 1 << `LLC_ADDR_BITS;
    localparam int WDOG_LIMIT = N_ROWS * ROW_CYCLES + 8;

    typedef struct packed {
        llc_cmd_t   cmd;
        line_addr_t addr;
        line_t      wdata;
        logic       exp_rd;
        logic       exp_wb;
        line_addr_t wb_addr;
    } row_t;

    logic       clk;
    logic       rst;
    logic       req_valid_i;
    llc_cmd_t   req_cmd_i;
    line_addr_t req_addr_i;
    line_t      req_wdata_i;
    logic       req_ready_o;
    logic       rsp_valid_o;
    line_t      rsp_data_o;
    logic       rsp_ready_i;
    logic       mem_req_valid_o;
    logic       mem_req_write_o;
    line_addr_t mem_req_addr_o;
    line_t      mem_req_data_o;
    logic       mem_req_ready_i;
    logic       mem_rsp_valid_i;
    line_t      mem_rsp_data_i;
    logic       mem_rsp_ready_o;

    row_t       rows [N_ROWS];
    int         n_loaded;
    line_t      mem_model [MEM_WORDS];
    line_t      shadow [MEM_WORDS];
    logic       shadow_written [MEM_WORDS];
    line_addr_t fetch_q [$];
    line_addr_t fetch_addr;
    line_addr_t rd_addr_log;
    line_addr_t wb_addr_log;
    line_t      wb_data_log;
    int         rd_count;
    int         wb_count;
    int         rsp_count;
    int         checks;
    int         errors;

    llc_core dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // memory contents before any write-back
    function automatic line_t init_value(input line_addr_t a);
        return {~a, a ^ 16'h5A3C};
    endfunction

    function automatic line_t expect_value(input line_addr_t a);
        return shadow_written[a] ? shadow[a] : init_value(a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // handshake outputs while reset is held
    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        check_value("req_ready_o", req_ready_o, 32'h1);
        check_value("rsp_valid_o", rsp_valid_o, 32'h0);
        check_value("mem_req_valid_o", mem_req_valid_o, 32'h0);
        check_value("mem_rsp_ready_o", mem_rsp_ready_o, 32'h0);
        $display("reset state: %s", (errors == err_before) ? "ok" : "FAIL");
    endtask

    task automatic add_row(input llc_cmd_t cmd, input line_addr_t addr, input line_t wdata,
                           input logic exp_rd, input logic exp_wb, input line_addr_t wb_addr);
        rows[n_loaded] = '{cmd, addr, wdata, exp_rd, exp_wb, wb_addr};
        n_loaded++;
    endtask

    // command, address, write data, fetch expected, write-back expected, its address
    task automatic load_table();
        // cold read, repeat, write hit, read back
        add_row(LLC_CMD_READ,  16'h1235, 32'h0,         1'b1, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'h1235, 32'h0,         1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h1235, 32'hC0DE_0001, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'h1235, 32'h0,         1'b0, 1'b0, 16'h0);
        // five tags into set 9 so the fifth evicts way 0
        add_row(LLC_CMD_WRITE, 16'h0109, 32'hA000_0109, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h0219, 32'hA000_0219, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h0329, 32'hA000_0329, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h0439, 32'hA000_0439, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h0549, 32'hA000_0549, 1'b0, 1'b1, 16'h0109);
        // each read-back miss pushes out the next dirty way
        add_row(LLC_CMD_READ,  16'h0109, 32'h0,         1'b1, 1'b1, 16'h0219);
        add_row(LLC_CMD_READ,  16'h0219, 32'h0,         1'b1, 1'b1, 16'h0329);
        add_row(LLC_CMD_READ,  16'h0329, 32'h0,         1'b1, 1'b1, 16'h0439);
        add_row(LLC_CMD_READ,  16'h0439, 32'h0,         1'b1, 1'b1, 16'h0549);
        add_row(LLC_CMD_READ,  16'h0549, 32'h0,         1'b1, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'h0109, 32'h0,         1'b1, 1'b0, 16'h0);
        // other sets
        add_row(LLC_CMD_WRITE, 16'h1235, 32'hC0DE_0002, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'h1235, 32'h0,         1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'hBEEF, 32'h0,         1'b1, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'hBEEF, 32'h0,         1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_WRITE, 16'h7777, 32'h5555_7777, 1'b0, 1'b0, 16'h0);
        add_row(LLC_CMD_READ,  16'h7777, 32'h0,         1'b0, 1'b0, 16'h0);
    endtask

    // memory side, logged at each handshake
    always @(posedge clk) begin
        if (rst && mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_write_o) begin
                mem_model[mem_req_addr_o] = mem_req_data_o;
                wb_addr_log = mem_req_addr_o;
                wb_data_log = mem_req_data_o;
                wb_count++;
            end else begin
                rd_addr_log = mem_req_addr_o;
                fetch_q.push_back(mem_req_addr_o);
                rd_count++;
            end
        end
        if (rst && rsp_valid_o && rsp_ready_i) begin
            rsp_count++;
        end
    end

    // fill data returns after a random delay
    always begin
        @(negedge clk);
        if (fetch_q.size() > 0) begin
            fetch_addr = fetch_q.pop_front();
            repeat ($urandom_range(0, 5)) @(negedge clk);
            mem_rsp_data_i  = mem_model[fetch_addr];
            mem_rsp_valid_i = 1'b1;
            do @(posedge clk); while (!mem_rsp_ready_o);
            @(negedge clk);
            mem_rsp_valid_i = 1'b0;
        end
    end

    // random stalls on both outgoing channels
    always @(negedge clk) begin
        rsp_ready_i     = ($urandom_range(0, 3) != 0);
        mem_req_ready_i = ($urandom_range(0, 3) != 0);
    end

    task automatic run_row(input int idx);
        row_t  r;
        line_t got;
        line_t exp_data;
        int    err_before;
        int    rd_before;
        int    wb_before;
        r          = rows[idx];
        err_before = errors;
        rd_before  = rd_count;
        wb_before  = wb_count;
        exp_data   = (r.cmd == LLC_CMD_WRITE) ? r.wdata : expect_value(r.addr);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_cmd_i   = r.cmd;
        req_addr_i  = r.addr;
        req_wdata_i = r.wdata;
        do @(posedge clk); while (!req_ready_o);
        @(negedge clk);
        req_valid_i = 1'b0;
        // request now in flight
        check_value("req_ready_o", req_ready_o, 32'h0);
        do @(posedge clk); while (!(rsp_valid_o && rsp_ready_i));
        got = rsp_data_o;
        // a write-back of a write miss can still be queued
        @(negedge clk);
        while (mem_req_valid_o) @(negedge clk);
        check_value("rsp_data_o", got, exp_data);
        check_value("mem_req_valid_o reads", rd_count - rd_before, r.exp_rd);
        check_value("mem_req_valid_o write-backs", wb_count - wb_before, r.exp_wb);
        check_value("mem_rsp_ready_o", mem_rsp_ready_o, 32'h0);
        if (r.exp_rd) begin
            check_value("mem_req_addr_o fetch", rd_addr_log, r.addr);
        end
        if (r.exp_wb) begin
            check_value("mem_req_addr_o write-back", wb_addr_log, r.wb_addr);
            check_value("mem_req_data_o write-back", wb_data_log, expect_value(r.wb_addr));
        end
        checks++;
        assert (!rsp_valid_o) else begin
            $display("row %0d got a second response", idx);
            errors++;
        end
        if (r.cmd == LLC_CMD_WRITE) begin
            shadow[r.addr]         = r.wdata;
            shadow_written[r.addr] = 1'b1;
        end
        $display("row %0d %s %h: %s", idx, (r.cmd == LLC_CMD_WRITE) ? "write" : "read",
                 r.addr, (errors == err_before) ? "ok" : "FAIL");
    endtask

    initial begin
        void'($urandom(89779));
        rst             = 1'b0;
        req_valid_i     = 1'b0;
        req_cmd_i       = LLC_CMD_READ;
        req_addr_i      = '0;
        req_wdata_i     = '0;
        rsp_ready_i     = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        n_loaded        = 0;
        rd_count        = 0;
        wb_count        = 0;
        rsp_count       = 0;
        checks          = 0;
        errors          = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_model[a]      = init_value(line_addr_t'(a));
            shadow_written[a] = 1'b0;
        end
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        rst = 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        check_value("rsp_valid_o handshakes", rsp_count, N_ROWS);
        $display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog scaled by the table length
    initial begin
        repeat (WDOG_LIMIT) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", WDOG_LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/llc_types_pkg.sv
rtl/llc_ctrl_pkg.sv
rtl/llc_input_decoder.sv
rtl/llc_localmem.sv
rtl/llc_lookup_way.sv
rtl/llc_process_request.sv
rtl/llc_output_regs.sv
rtl/llc_core.sv
verif/llc_core_tb.sv

// ==== Bender.yml ====
package:
  name: llc_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/llc_types_pkg.sv
      - rtl/llc_ctrl_pkg.sv
      - rtl/llc_input_decoder.sv
      - rtl/llc_localmem.sv
      - rtl/llc_lookup_way.sv
      - rtl/llc_process_request.sv
      - rtl/llc_output_regs.sv
      - rtl/llc_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/llc_core_tb.sv
